/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	////////////////////
	// widths
	////////////////////

	// data word and pc share one width
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int immWidth = 17;
	localparam int targetWidth = 27;

	// data memory lives inside the core
	localparam int dmemAddrWidth = 8;
	localparam int dmemDepth = 256;

	////////////////////
	// types
	////////////////////

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// jal writes its link value here
	localparam regAddrT linkReg = 5'd31;

	// top five bits of every instruction
	typedef enum logic [4:0] {
		opAlu = 5'd0,
		opJ = 5'd1,
		opBne = 5'd2,
		opJal = 5'd3,
		opAddi = 5'd5,
		opBlt = 5'd6,
		opSw = 5'd7,
		opLw = 5'd8
	} opcodeT;

	// aluop field, only meaningful for opAlu
	typedef enum logic [4:0] {
		aluAdd = 5'd0,
		aluSub = 5'd1,
		aluAnd = 5'd2,
		aluOr = 5'd3,
		aluSll = 5'd4,
		aluSra = 5'd5
	} aluOpT;

endpackage

`default_nettype wire

/* design/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
	input wire logic clock,
	input wire logic arstN,
	input wire cpuPkg::wordT instr,
	input wire logic stall,
	input wire logic redirect,
	input wire cpuPkg::wordT redirectPc,
	output cpuPkg::wordT instrAddr,
	output cpuPkg::wordT fdPc,
	output cpuPkg::wordT fdInstr
);

	cpuPkg::wordT pc;
	cpuPkg::wordT pcPlusOne;
	cpuPkg::wordT pcNext;

	// instruction ROM answers in the same cycle
	assign instrAddr = pc;
	assign pcPlusOne = pc + 32'd1;

	// redirect wins over a stall
	always_comb begin
		if (redirect) begin
			pcNext = redirectPc;
		end else if (stall) begin
			pcNext = pc;
		end else begin
			pcNext = pcPlusOne;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

	////////////////////
	// fetch/decode register
	////////////////////

	// an all-zero word decodes as add r0, r0, r0
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			fdPc <= '0;
			fdInstr <= '0;
		end else if (redirect) begin
			fdPc <= '0;
			fdInstr <= '0;
		end else if (!stall) begin
			fdPc <= pcPlusOne;
			fdInstr <= instr;
		end
	end

endmodule

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input wire logic clock,
	input wire logic arstN,
	input wire cpuPkg::regAddrT readA,
	input wire cpuPkg::regAddrT readB,
	input wire logic wbWrite,
	input wire cpuPkg::regAddrT wbReg,
	input wire cpuPkg::wordT wbData,
	output cpuPkg::wordT valueA,
	output cpuPkg::wordT valueB
);

	// register 0 has no storage
	cpuPkg::wordT regs [1:(1 << cpuPkg::regAddrWidth) - 1];

	// write-through, so decode sees the value retiring this cycle
	function automatic cpuPkg::wordT readPort(input cpuPkg::regAddrT addr);
		cpuPkg::wordT value;
		if (addr == '0) begin
			value = '0;
		end else if (wbWrite && wbReg == addr) begin
			value = wbData;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		valueA = readPort(readA);
		valueB = readPort(readB);
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < (1 << cpuPkg::regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input wire logic clock,
	input wire logic arstN,
	input wire cpuPkg::wordT fdPc,
	input wire cpuPkg::wordT fdInstr,
	input wire logic redirect,
	input wire logic wbWrite,
	input wire cpuPkg::regAddrT wbReg,
	input wire cpuPkg::wordT wbData,
	output logic stall,
	output cpuPkg::opcodeT dxOpcode,
	output cpuPkg::aluOpT dxAluOp,
	output logic [cpuPkg::regAddrWidth-1:0] dxShamt,
	output logic [cpuPkg::regAddrWidth-1:0] dxRd,
	output logic [cpuPkg::regAddrWidth-1:0] dxRs,
	output cpuPkg::regAddrT dxSrc2,
	output cpuPkg::wordT dxRsValue,
	output cpuPkg::wordT dxSrc2Value,
	output cpuPkg::wordT dxPc,
	output logic [cpuPkg::immWidth-1:0] dxImm,
	output logic [cpuPkg::targetWidth-1:0] dxTarget
);

	cpuPkg::opcodeT opcode;
	cpuPkg::aluOpT aluOp;
	cpuPkg::regAddrT rd;
	cpuPkg::regAddrT rs;
	cpuPkg::regAddrT rt;
	cpuPkg::regAddrT src2;
	logic [cpuPkg::regAddrWidth-1:0] shamt;
	cpuPkg::wordT rsValue;
	cpuPkg::wordT src2Value;

	////////////////////
	// field split
	////////////////////

	assign opcode = cpuPkg::opcodeT'(fdInstr[31:27]);
	assign rd = fdInstr[26:22];
	assign rs = fdInstr[21:17];
	assign rt = fdInstr[16:12];
	assign shamt = fdInstr[11:7];
	assign aluOp = cpuPkg::aluOpT'(fdInstr[6:2]);

	// branches and stores read rd as their second operand
	assign src2 = (opcode == cpuPkg::opAlu) ? rt : rd;

	registerFile regs (
		.clock(clock),
		.arstN(arstN),
		.readA(rs),
		.readB(src2),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.valueA(rsValue),
		.valueB(src2Value)
	);

	// load in execute has no data until its memory stage
	assign stall = (dxOpcode == cpuPkg::opLw) && (dxRd != '0)
		&& ((dxRd == rs) || (dxRd == src2));

	////////////////////
	// decode/execute register
	////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dxOpcode <= cpuPkg::opAlu;
			dxAluOp <= cpuPkg::aluAdd;
			dxRd <= '0;
			dxRs <= '0;
			dxSrc2 <= '0;
			dxShamt <= '0;
		end else if (redirect || stall) begin
			// bubble
			dxOpcode <= cpuPkg::opAlu;
			dxAluOp <= cpuPkg::aluAdd;
			dxRd <= '0;
			dxRs <= '0;
			dxSrc2 <= '0;
			dxShamt <= '0;
		end else begin
			dxOpcode <= opcode;
			dxAluOp <= aluOp;
			dxRd <= rd;
			dxRs <= rs;
			dxSrc2 <= src2;
			dxShamt <= shamt;
		end
	end

	always_ff @(posedge clock) begin
		dxRsValue <= rsValue;
		dxSrc2Value <= src2Value;
		dxPc <= fdPc;
		dxImm <= fdInstr[cpuPkg::immWidth-1:0];
		dxTarget <= fdInstr[cpuPkg::targetWidth-1:0];
	end

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input wire logic clock,
	input wire logic arstN,
	input wire cpuPkg::opcodeT dxOpcode,
	input wire cpuPkg::aluOpT dxAluOp,
	input wire logic [cpuPkg::regAddrWidth-1:0] dxShamt,
	input wire logic [cpuPkg::regAddrWidth-1:0] dxRd,
	input wire logic [cpuPkg::regAddrWidth-1:0] dxRs,
	input wire cpuPkg::regAddrT dxSrc2,
	input wire cpuPkg::wordT dxRsValue,
	input wire cpuPkg::wordT dxSrc2Value,
	input wire cpuPkg::wordT dxPc,
	input wire logic [cpuPkg::immWidth-1:0] dxImm,
	input wire logic [cpuPkg::targetWidth-1:0] dxTarget,
	input wire logic wbWrite,
	input wire cpuPkg::regAddrT wbReg,
	input wire cpuPkg::wordT wbData,
	output logic redirect,
	output cpuPkg::wordT redirectPc,
	output cpuPkg::opcodeT xmOpcode,
	output cpuPkg::regAddrT xmRd,
	output cpuPkg::wordT xmAlu,
	output cpuPkg::wordT xmStoreData,
	output cpuPkg::wordT xmPc
);

	cpuPkg::wordT rsFwd;
	cpuPkg::wordT src2Fwd;
	cpuPkg::wordT immExt;
	cpuPkg::wordT targetExt;
	cpuPkg::wordT aluResult;
	cpuPkg::wordT xmFwdValue;
	cpuPkg::regAddrT xmDest;
	logic xmWritesReg;

	assign immExt = {{(cpuPkg::dataWidth - cpuPkg::immWidth){dxImm[cpuPkg::immWidth-1]}}, dxImm};
	assign targetExt = {{(cpuPkg::dataWidth - cpuPkg::targetWidth){1'b0}}, dxTarget};

	////////////////////
	// forwarding
	////////////////////

	// a load in the memory stage is never a source, the stall covers it
	assign xmWritesReg = (xmOpcode == cpuPkg::opAlu) || (xmOpcode == cpuPkg::opAddi)
		|| (xmOpcode == cpuPkg::opJal);
	assign xmDest = (xmOpcode == cpuPkg::opJal) ? cpuPkg::linkReg : xmRd;
	assign xmFwdValue = (xmOpcode == cpuPkg::opJal) ? xmPc : xmAlu;

	// memory stage is younger, so it beats writeback
	function automatic cpuPkg::wordT forward(input cpuPkg::regAddrT src,
			input cpuPkg::wordT regValue);
		cpuPkg::wordT value;
		value = regValue;
		if (src != '0 && xmWritesReg && xmDest == src) begin
			value = xmFwdValue;
		end else if (wbWrite && wbReg == src) begin
			value = wbData;
		end
		return value;
	endfunction

	always_comb begin
		rsFwd = forward(dxRs, dxRsValue);
		src2Fwd = forward(dxSrc2, dxSrc2Value);
	end

	////////////////////
	// alu
	////////////////////

	// everything but register ops computes rs + imm
	always_comb begin
		aluResult = rsFwd + immExt;
		if (dxOpcode == cpuPkg::opAlu) begin
			case (dxAluOp)
				cpuPkg::aluSub: aluResult = rsFwd - src2Fwd;
				cpuPkg::aluAnd: aluResult = rsFwd & src2Fwd;
				cpuPkg::aluOr: aluResult = rsFwd | src2Fwd;
				cpuPkg::aluSll: aluResult = rsFwd << dxShamt;
				cpuPkg::aluSra: aluResult = $signed(rsFwd) >>> dxShamt;
				default: aluResult = rsFwd + src2Fwd;
			endcase
		end
	end

	// dxPc already holds pc+1
	always_comb begin
		redirect = 1'b0;
		redirectPc = dxPc + immExt;
		case (dxOpcode)
			cpuPkg::opBne: redirect = (src2Fwd != rsFwd);
			cpuPkg::opBlt: redirect = ($signed(src2Fwd) < $signed(rsFwd));
			cpuPkg::opJ, cpuPkg::opJal: begin
				redirect = 1'b1;
				redirectPc = targetExt;
			end
			default: redirect = 1'b0;
		endcase
	end

	////////////////////
	// execute/memory register
	////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			xmOpcode <= cpuPkg::opAlu;
			xmRd <= '0;
		end else begin
			xmOpcode <= dxOpcode;
			xmRd <= dxRd;
		end
	end

	always_ff @(posedge clock) begin
		xmAlu <= aluResult;
		xmStoreData <= src2Fwd;
		xmPc <= dxPc;
	end

endmodule

`default_nettype wire

/* design/resultStage.sv */
`timescale 1ns/100ps
`default_nettype none

module resultStage (
	input wire logic clock,
	input wire logic arstN,
	input wire cpuPkg::opcodeT xmOpcode,
	input wire cpuPkg::regAddrT xmRd,
	input wire cpuPkg::wordT xmAlu,
	input wire cpuPkg::wordT xmStoreData,
	input wire cpuPkg::wordT xmPc,
	output logic memWrite,
	output logic [cpuPkg::dmemAddrWidth-1:0] memAddr,
	output cpuPkg::wordT memData,
	output logic wbWrite,
	output cpuPkg::regAddrT wbReg,
	output cpuPkg::wordT wbData
);

	cpuPkg::wordT dataMem [0:cpuPkg::dmemDepth-1];
	cpuPkg::wordT loadData;
	cpuPkg::wordT wbNext;
	cpuPkg::regAddrT destReg;
	logic writesReg;

	////////////////////
	// data memory
	////////////////////

	assign memWrite = (xmOpcode == cpuPkg::opSw);
	assign memAddr = xmAlu[cpuPkg::dmemAddrWidth-1:0];
	assign memData = xmStoreData;
	assign loadData = dataMem[memAddr];

	always_ff @(posedge clock) begin
		if (memWrite) begin
			dataMem[memAddr] <= memData;
		end
	end

	// writeback select ahead of the register
	always_comb begin
		destReg = (xmOpcode == cpuPkg::opJal) ? cpuPkg::linkReg : xmRd;
		case (xmOpcode)
			cpuPkg::opJal: wbNext = xmPc;
			cpuPkg::opLw: wbNext = loadData;
			default: wbNext = xmAlu;
		endcase
		writesReg = ((xmOpcode == cpuPkg::opAlu) || (xmOpcode == cpuPkg::opAddi)
			|| (xmOpcode == cpuPkg::opLw) || (xmOpcode == cpuPkg::opJal))
			&& (destReg != '0);
	end

	////////////////////
	// memory/writeback register
	////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbWrite <= 1'b0;
			wbReg <= '0;
		end else begin
			wbWrite <= writesReg;
			wbReg <= destReg;
		end
	end

	always_ff @(posedge clock) begin
		wbData <= wbNext;
	end

endmodule

`default_nettype wire

/* design/pipelineCpu.sv */
`timescale 1ns/100ps
`default_nettype none

module pipelineCpu (
	input wire logic clock,
	input wire logic arstN,
	output cpuPkg::wordT instrAddr,
	input wire cpuPkg::wordT instr,
	output logic regWrite,
	output cpuPkg::regAddrT regAddr,
	output cpuPkg::wordT regData,
	output logic memWrite,
	output logic [cpuPkg::dmemAddrWidth-1:0] memAddr,
	output cpuPkg::wordT memData
);

	// fetch to decode
	cpuPkg::wordT fdPc;
	cpuPkg::wordT fdInstr;
	logic stall;
	logic redirect;
	cpuPkg::wordT redirectPc;

	// decode to execute
	cpuPkg::opcodeT dxOpcode;
	cpuPkg::aluOpT dxAluOp;
	logic [cpuPkg::regAddrWidth-1:0] dxShamt;
	logic [cpuPkg::regAddrWidth-1:0] dxRd;
	logic [cpuPkg::regAddrWidth-1:0] dxRs;
	cpuPkg::regAddrT dxSrc2;
	cpuPkg::wordT dxRsValue;
	cpuPkg::wordT dxSrc2Value;
	cpuPkg::wordT dxPc;
	logic [cpuPkg::immWidth-1:0] dxImm;
	logic [cpuPkg::targetWidth-1:0] dxTarget;

	// execute to memory, then writeback
	cpuPkg::opcodeT xmOpcode;
	cpuPkg::regAddrT xmRd;
	cpuPkg::wordT xmAlu;
	cpuPkg::wordT xmStoreData;
	cpuPkg::wordT xmPc;
	logic wbWrite;
	cpuPkg::regAddrT wbReg;
	cpuPkg::wordT wbData;

	fetchUnit fetch (
		.clock(clock), .arstN(arstN), .instr(instr), .stall(stall),
		.redirect(redirect), .redirectPc(redirectPc), .instrAddr(instrAddr),
		.fdPc(fdPc), .fdInstr(fdInstr)
	);

	decodeStage decode (
		.clock(clock), .arstN(arstN), .fdPc(fdPc), .fdInstr(fdInstr),
		.redirect(redirect), .wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
		.stall(stall), .dxOpcode(dxOpcode), .dxAluOp(dxAluOp), .dxShamt(dxShamt),
		.dxRd(dxRd), .dxRs(dxRs), .dxSrc2(dxSrc2), .dxRsValue(dxRsValue),
		.dxSrc2Value(dxSrc2Value), .dxPc(dxPc), .dxImm(dxImm), .dxTarget(dxTarget)
	);

	executeStage execute (
		.clock(clock), .arstN(arstN), .dxOpcode(dxOpcode), .dxAluOp(dxAluOp),
		.dxShamt(dxShamt), .dxRd(dxRd), .dxRs(dxRs), .dxSrc2(dxSrc2),
		.dxRsValue(dxRsValue), .dxSrc2Value(dxSrc2Value), .dxPc(dxPc),
		.dxImm(dxImm), .dxTarget(dxTarget), .wbWrite(wbWrite), .wbReg(wbReg),
		.wbData(wbData), .redirect(redirect), .redirectPc(redirectPc),
		.xmOpcode(xmOpcode), .xmRd(xmRd), .xmAlu(xmAlu),
		.xmStoreData(xmStoreData), .xmPc(xmPc)
	);

	resultStage result (
		.clock(clock), .arstN(arstN), .xmOpcode(xmOpcode), .xmRd(xmRd),
		.xmAlu(xmAlu), .xmStoreData(xmStoreData), .xmPc(xmPc),
		.memWrite(memWrite), .memAddr(memAddr), .memData(memData),
		.wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData)
	);

	// the writeback event is visible at the top
	assign regWrite = wbWrite;
	assign regAddr = wbReg;
	assign regData = wbData;

endmodule

`default_nettype wire

/* testbench/pipelineCpu_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module pipelineCpuAssertions (
	input wire logic clock,
	input wire logic arstN,
	input wire logic stall,
	input wire logic regWrite,
	input wire cpuPkg::regAddrT regAddr,
	input wire logic memWrite
);

	// register 0 writes are dropped before writeback
	regZeroNeverWritten: assert property (@(posedge clock) disable iff (!arstN)
		regWrite |-> regAddr != '0)
		else $error("writeback to register 0");

	// the bubble behind a load is never a load itself
	stallSingleCycle: assert property (@(posedge clock) disable iff (!arstN)
		stall |=> !stall)
		else $error("stall high in two consecutive cycles");

	// only reset bubbles reach memory and writeback in that cycle
	quietAfterReset: assert property (@(posedge clock)
		$rose(arstN) |=> !regWrite && !memWrite)
		else $error("write event in the first cycle after reset");

endmodule

bind pipelineCpu pipelineCpuAssertions checks (
	.clock(clock), .arstN(arstN), .stall(stall),
	.regWrite(regWrite), .regAddr(regAddr), .memWrite(memWrite)
);

`default_nettype wire

/* testbench/pipelineCpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module pipelineCpuTb;

	localparam int progLen = 40;
	localparam int numTests = 5;
	localparam int cycleLimit = 3 * progLen + 20;
	// loads and stores only touch these words, base r0
	localparam int numAddrs = 4;

	logic clock;
	logic arstN;
	cpuPkg::wordT instrAddr;
	cpuPkg::wordT instr;
	logic regWrite;
	cpuPkg::regAddrT regAddr;
	cpuPkg::wordT regData;
	logic memWrite;
	logic [cpuPkg::dmemAddrWidth-1:0] memAddr;
	cpuPkg::wordT memData;

	cpuPkg::wordT prog [progLen];
	cpuPkg::wordT modelRegs [32];
	cpuPkg::wordT modelMem [cpuPkg::dmemDepth];
	cpuPkg::regAddrT expRegAddr [$];
	cpuPkg::wordT expRegData [$];
	logic [cpuPkg::dmemAddrWidth-1:0] expMemAddr [$];
	cpuPkg::wordT expMemData [$];

	integer seed;
	int errors;
	int passedTests;
	int cycles;
	int lastFetches;
	int testNum;
	logic running;
	logic timedOut;

	pipelineCpu dut (
		.clock(clock), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
		.regWrite(regWrite), .regAddr(regAddr), .regData(regData),
		.memWrite(memWrite), .memAddr(memAddr), .memData(memData)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	// instruction ROM, nops past the end of the program
	always_comb begin
		if (instrAddr < 32'(progLen)) begin
			instr = prog[instrAddr[5:0]];
		end else begin
			instr = '0;
		end
	end

	////////////////////
	// program generation
	////////////////////

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	// mostly a few low registers so that chains form, r31 now and then
	function automatic cpuPkg::regAddrT pickReg();
		int r;
		r = pick(9);
		return (r == 8) ? cpuPkg::linkReg : 5'(r);
	endfunction

	function automatic cpuPkg::wordT aluWord(input cpuPkg::aluOpT op, input cpuPkg::regAddrT rd,
			input cpuPkg::regAddrT rs, input cpuPkg::regAddrT rt, input logic [4:0] shamt);
		return {cpuPkg::opAlu, rd, rs, rt, shamt, op, 2'b00};
	endfunction

	function automatic cpuPkg::wordT immWord(input cpuPkg::opcodeT op, input cpuPkg::regAddrT rd,
			input cpuPkg::regAddrT rs, input logic [16:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic cpuPkg::wordT jumpWord(input cpuPkg::opcodeT op, input logic [26:0] target);
		return {op, target};
	endfunction

	task automatic makeProgram();
		int kind;
		int span;
		cpuPkg::regAddrT rd;
		cpuPkg::regAddrT rs;
		// data memory is not reset, so the words in use get defined first
		for (int i = 0; i < numAddrs; i++) begin
			prog[i] = immWord(cpuPkg::opSw, 5'd0, 5'd0, 17'(i));
		end
		for (int slot = numAddrs; slot < progLen - 1; slot++) begin
			kind = pick(10);
			rd = pickReg();
			rs = pickReg();
			// forward targets only, never past the final jump
			span = (progLen - 2 - slot < 3) ? progLen - 2 - slot : 3;
			case (kind)
				0, 1, 2: prog[slot] = aluWord(cpuPkg::aluOpT'(5'(pick(6))), rd, rs, pickReg(),
					5'(pick(32)));
				3: prog[slot] = immWord(cpuPkg::opAddi, rd, rs, 17'(pick(16) - 8));
				4: prog[slot] = immWord(cpuPkg::opLw, rd, 5'd0, 17'(pick(numAddrs)));
				5: prog[slot] = immWord(cpuPkg::opSw, rd, 5'd0, 17'(pick(numAddrs)));
				6: prog[slot] = immWord(cpuPkg::opBne, rd, rs, 17'(pick(span + 1)));
				7: prog[slot] = immWord(cpuPkg::opBlt, rd, rs, 17'(pick(span + 1)));
				8: prog[slot] = jumpWord(cpuPkg::opJ, 27'(slot + 1 + pick(span + 1)));
				default: prog[slot] = jumpWord(cpuPkg::opJal, 27'(slot + 1 + pick(span + 1)));
			endcase
		end
		prog[progLen-1] = jumpWord(cpuPkg::opJ, 27'(progLen - 1));
	endtask

	////////////////////
	// instruction-set model
	////////////////////

	function automatic void recordWrite(input cpuPkg::regAddrT r, input cpuPkg::wordT value);
		if (r != '0) begin
			modelRegs[r] = value;
			expRegAddr.push_back(r);
			expRegData.push_back(value);
		end
	endfunction

	task automatic runModel();
		int pc;
		cpuPkg::wordT ins;
		cpuPkg::wordT a;
		cpuPkg::wordT b;
		cpuPkg::wordT imm;
		cpuPkg::wordT result;
		logic [cpuPkg::dmemAddrWidth-1:0] addr;
		expRegAddr.delete();
		expRegData.delete();
		expMemAddr.delete();
		expMemData.delete();
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		pc = 0;
		// stops at the self jump
		while (pc != progLen - 1) begin
			ins = prog[pc];
			a = modelRegs[ins[21:17]];
			b = modelRegs[ins[16:12]];
			imm = {{15{ins[16]}}, ins[16:0]};
			addr = 8'(a + imm);
			pc = pc + 1;
			case (cpuPkg::opcodeT'(ins[31:27]))
				cpuPkg::opAlu: begin
					case (cpuPkg::aluOpT'(ins[6:2]))
						cpuPkg::aluSub: result = a - b;
						cpuPkg::aluAnd: result = a & b;
						cpuPkg::aluOr: result = a | b;
						cpuPkg::aluSll: result = a << ins[11:7];
						cpuPkg::aluSra: result = $signed(a) >>> ins[11:7];
						default: result = a + b;
					endcase
					recordWrite(ins[26:22], result);
				end
				cpuPkg::opAddi: recordWrite(ins[26:22], a + imm);
				cpuPkg::opLw: recordWrite(ins[26:22], modelMem[addr]);
				cpuPkg::opSw: begin
					modelMem[addr] = modelRegs[ins[26:22]];
					expMemAddr.push_back(addr);
					expMemData.push_back(modelRegs[ins[26:22]]);
				end
				cpuPkg::opBne: if (modelRegs[ins[26:22]] != a) pc = pc + int'(imm);
				cpuPkg::opBlt: if ($signed(modelRegs[ins[26:22]]) < $signed(a)) pc = pc + int'(imm);
				cpuPkg::opJal: begin
					recordWrite(cpuPkg::linkReg, 32'(pc));
					pc = int'(ins[26:0]);
				end
				default: pc = int'(ins[26:0]);
			endcase
		end
	endtask

	////////////////////
	// checking
	////////////////////

	task automatic compareReg(input cpuPkg::regAddrT gotAddr, input cpuPkg::wordT gotData);
		cpuPkg::regAddrT wantAddr;
		cpuPkg::wordT wantData;
		if (expRegAddr.size() == 0) begin
			$display("time %0t: write to r%0d that the model did not expect", $time, gotAddr);
			errors++;
		end else begin
			wantAddr = expRegAddr.pop_front();
			wantData = expRegData.pop_front();
			if (gotAddr !== wantAddr) begin
				$display("CHECK FAILED time %0t regAddr got %0d expected %0d", $time,
					gotAddr, wantAddr);
				errors++;
			end
			if (gotData !== wantData) begin
				$display("CHECK FAILED time %0t regData got %h expected %h", $time,
					gotData, wantData);
				errors++;
			end
		end
	endtask

	task automatic compareMem(input logic [cpuPkg::dmemAddrWidth-1:0] gotAddr,
			input cpuPkg::wordT gotData);
		logic [cpuPkg::dmemAddrWidth-1:0] wantAddr;
		cpuPkg::wordT wantData;
		if (expMemAddr.size() == 0) begin
			$display("time %0t: store to %0d that the model did not expect", $time, gotAddr);
			errors++;
		end else begin
			wantAddr = expMemAddr.pop_front();
			wantData = expMemData.pop_front();
			if (gotAddr !== wantAddr) begin
				$display("CHECK FAILED time %0t memAddr got %0d expected %0d", $time,
					gotAddr, wantAddr);
				errors++;
			end
			if (gotData !== wantData) begin
				$display("CHECK FAILED time %0t memData got %h expected %h", $time,
					gotData, wantData);
				errors++;
			end
		end
	endtask

	always @(posedge clock) begin
		if (running) begin
			if (regWrite) compareReg(regAddr, regData);
			if (memWrite) compareMem(memAddr, memData);
			if (instrAddr == 32'(progLen - 1)) lastFetches++;
			cycles++;
		end
	end

	task automatic runTest(input int num);
		int startErrors;
		startErrors = errors;
		@(negedge clock);
		arstN = 1'b0;
		running = 1'b0;
		makeProgram();
		runModel();
		repeat (4) @(negedge clock);
		cycles = 0;
		lastFetches = 0;
		arstN = 1'b1;
		running = 1'b1;
		// the self jump fetched four times means everything older has retired
		while (lastFetches < 4 && cycles < cycleLimit) @(negedge clock);
		running = 1'b0;
		if (lastFetches < 4) begin
			$display("test %0d: final jump not reached within %0d cycles", num, cycleLimit);
			errors++;
			timedOut = 1'b1;
		end
		if (expRegAddr.size() != 0 || expMemAddr.size() != 0) begin
			$display("test %0d: %0d register writes and %0d stores never came", num,
				expRegAddr.size(), expMemAddr.size());
			errors++;
		end
		if (errors == startErrors) passedTests++;
		$display("test %0d finished with %0d errors", num, errors - startErrors);
	endtask

	initial begin
		seed = 32'h1f8f_c3c2;
		arstN = 1'b0;
		running = 1'b0;
		timedOut = 1'b0;
		errors = 0;
		passedTests = 0;
		testNum = 0;
		while (testNum < numTests && !timedOut) begin
			runTest(testNum);
			testNum++;
		end
		$display("%0d of %0d tests passed, %0d errors", passedTests, numTests, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
design/cpuPkg.sv
design/fetchUnit.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/pipelineCpu.sv
testbench/pipelineCpu_assertions.sv
testbench/pipelineCpuTb.sv

/* runSim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pipelineCpuTb -f files.f -o simv \
	|| { echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
